//--- build.f
+incdir+include
design/frogger_pkg.sv
design/vga_timing.sv
design/button_press.sv
design/frog_control.sv
design/traffic.sv
design/score_display.sv
design/pixel_render.sv
design/frogger_top.sv
dv/tb_frogger.sv

//--- Bender.yml
package:
  name: frogger

export_include_dirs:
  - include

sources:
  - design/frogger_pkg.sv
  - design/vga_timing.sv
  - design/button_press.sv
  - design/frog_control.sv
  - design/traffic.sv
  - design/score_display.sv
  - design/pixel_render.sv
  - design/frogger_top.sv
  - target: simulation
    files:
      - dv/tb_frogger.sv

//--- dv/tb_frogger.sv
`timescale 1ns/1ps
`include "frogger_config.svh"

module tb_frogger;

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int FROG_PIXELS = `TILE * `TILE;
    localparam frogger_pkg::seg_t SEG_ZERO = 7'b0000001;
    localparam frogger_pkg::seg_t SEG_ONE = 7'b1001111;
    localparam frogger_pkg::buttons_t BTN_UP = '{up: 1'b1, left: 1'b0, right: 1'b0, down: 1'b0};
    localparam frogger_pkg::buttons_t BTN_RIGHT = '{up: 1'b0, left: 1'b0, right: 1'b1, down: 1'b0};
    localparam frogger_pkg::buttons_t BTN_ALL = '{up: 1'b1, left: 1'b1, right: 1'b1, down: 1'b1};

    logic i_CLK;
    logic i_rst;
    frogger_pkg::buttons_t i_buttons;
    logic o_hsync;
    logic o_vsync;
    frogger_pkg::rgb_t o_rgb;
    frogger_pkg::seg_t o_seg_tens;
    frogger_pkg::seg_t o_seg_ones;

    logic hsync_d;
    logic vsync_d;
    logic hs_fall_seen;
    logic pos_valid;
    logic in_frame;
    int hs_low_len;
    int vs_low_len;
    int hs_period;
    int h_pos;
    int v_pos;
    int frog_px;
    int frames_done;

    frogger_pkg::seg_t exp_tens;
    frogger_pkg::seg_t exp_ones;
    logic score_stable;

    frogger_top #(
        .CAR_TICK        (10000000),
        .DEBOUNCE_CYCLES (4)
    ) dut0 (
        .i_CLK      (i_CLK),
        .i_rst      (i_rst),
        .i_buttons  (i_buttons),
        .o_hsync    (o_hsync),
        .o_vsync    (o_vsync),
        .o_rgb      (o_rgb),
        .o_seg_tens (o_seg_tens),
        .o_seg_ones (o_seg_ones)
    );

    initial begin
        i_CLK = 1'b0;
        forever #20 i_CLK = ~i_CLK;
    end

    // Rebuild the scan position from the sync edges
    always @(posedge i_CLK) begin : scan_model
        int h_now;
        int v_now;
        if (i_rst) begin
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            hs_fall_seen <= 1'b0;
            pos_valid <= 1'b0;
            in_frame <= 1'b0;
            hs_low_len <= 0;
            vs_low_len <= 0;
            hs_period <= 0;
            h_pos <= 0;
            v_pos <= 0;
            frog_px <= 0;
            frames_done <= 0;
        end else begin
            hsync_d <= o_hsync;
            vsync_d <= o_vsync;
            hs_low_len <= o_hsync ? 0 : hs_low_len + 1;
            vs_low_len <= o_vsync ? 0 : vs_low_len + 1;
            if (!o_hsync && hsync_d) begin
                hs_period <= 1;
                hs_fall_seen <= 1'b1;
                h_now = `H_ACTIVE + `H_FRONT;
            end else begin
                hs_period <= hs_period + 1;
                h_now = (h_pos == H_TOTAL - 1) ? 0 : h_pos + 1;
            end
            if (!o_vsync && vsync_d) begin
                v_now = `V_ACTIVE + `V_FRONT;
                pos_valid <= 1'b1;
            end else if (h_now == 0) begin
                v_now = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
            end else begin
                v_now = v_pos;
            end
            h_pos <= h_now;
            v_pos <= v_now;
            // o_rgb lags the scan by one cycle and belongs to the old position
            if (pos_valid) begin
                if (h_pos == 0 && v_pos == 0) begin
                    in_frame <= 1'b1;
                    frog_px <= (o_rgb == `COLOR_FROG) ? 1 : 0;
                end else if (o_rgb == `COLOR_FROG) begin
                    frog_px <= frog_px + 1;
                end
                if (in_frame && h_pos == H_TOTAL - 1 && v_pos == V_TOTAL - 1) begin
                    frames_done <= frames_done + 1;
                end
            end
        end
    end

    hsync_width_check: assert property (@(posedge i_CLK) disable iff (i_rst)
        (o_hsync && !hsync_d) |-> hs_low_len == `H_SYNC)
    else begin
        $display("Error: o_hsync low length %h, expected %h", $sampled(hs_low_len), `H_SYNC);
        fail_run();
    end

    hsync_period_check: assert property (@(posedge i_CLK) disable iff (i_rst)
        (!o_hsync && hsync_d && hs_fall_seen) |-> hs_period == H_TOTAL)
    else begin
        $display("Error: o_hsync period %h, expected %h", $sampled(hs_period), H_TOTAL);
        fail_run();
    end

    vsync_width_check: assert property (@(posedge i_CLK) disable iff (i_rst)
        (o_vsync && !vsync_d) |-> vs_low_len == `V_SYNC * H_TOTAL)
    else begin
        $display("Error: o_vsync low length %h, expected %h", $sampled(vs_low_len),
                 `V_SYNC * H_TOTAL);
        fail_run();
    end

    blank_rgb_check: assert property (@(posedge i_CLK) disable iff (i_rst)
        (pos_valid && (h_pos >= `H_ACTIVE || v_pos >= `V_ACTIVE)) |-> o_rgb == '0)
    else begin
        $display("Error: o_rgb %h in blanking at x %h y %h, expected %h",
                 $sampled(o_rgb), $sampled(h_pos), $sampled(v_pos), 6'h00);
        fail_run();
    end

    frog_pixels_check: assert property (@(posedge i_CLK) disable iff (i_rst)
        (pos_valid && in_frame && frames_done == 0 && h_pos == H_TOTAL - 1 &&
         v_pos == V_TOTAL - 1) |-> frog_px == FROG_PIXELS)
    else begin
        $display("Error: o_rgb frog pixel count %h, expected %h", $sampled(frog_px),
                 FROG_PIXELS);
        fail_run();
    end

    score_digits_check: assert property (@(posedge i_CLK) disable iff (i_rst)
        score_stable |-> (o_seg_tens == exp_tens && o_seg_ones == exp_ones))
    else begin
        $display("Error: o_seg_tens %h o_seg_ones %h, expected %h %h",
                 $sampled(o_seg_tens), $sampled(o_seg_ones),
                 $sampled(exp_tens), $sampled(exp_ones));
        fail_run();
    end

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Hold the buttons low for 10 cycles, release for 10, then a random gap
    task automatic press_buttons(input frogger_pkg::buttons_t mask, input int times);
        int gap;
        for (int n = 0; n < times; n++) begin
            gap = 20 + int'($urandom % 41);
            @(posedge i_CLK);
            i_buttons <= ~mask;
            repeat (10) @(posedge i_CLK);
            i_buttons <= '1;
            repeat (10 + gap) @(posedge i_CLK);
        end
    endtask

    task automatic wait_for_score(input frogger_pkg::seg_t tens, input frogger_pkg::seg_t ones,
                                  input int limit);
        int cycles;
        cycles = 0;
        exp_tens <= tens;
        exp_ones <= ones;
        while (!(o_seg_tens == tens && o_seg_ones == ones)) begin
            if (cycles == limit) begin
                $display("The score display did not reach the expected digits in time");
                fail_run();
            end
            @(posedge i_CLK);
            cycles++;
        end
        score_stable <= 1'b1;
        repeat (20) @(posedge i_CLK);
    endtask

    task automatic wait_for_frame(input int limit);
        int cycles;
        cycles = 0;
        while (frames_done == 0) begin
            if (cycles == limit) begin
                $display("No complete video frame was seen in time");
                fail_run();
            end
            @(posedge i_CLK);
            cycles++;
        end
    endtask

    initial begin
        i_rst = 1'b1;
        i_buttons = '1;
        score_stable = 1'b0;
        exp_tens = SEG_ZERO;
        exp_ones = SEG_ZERO;
        void'($urandom(15));
        repeat (10) @(posedge i_CLK);
        i_rst <= 1'b0;

        wait_for_score(SEG_ZERO, SEG_ZERO, 100);
        wait_for_frame(3 * FRAME_CYCLES);

        // Column 10 never meets a car and the fifteenth hop scores
        score_stable <= 1'b0;
        press_buttons(BTN_UP, 15);
        wait_for_score(SEG_ZERO, SEG_ONE, 500);

        // Col 13 in row 13 lands on car 2
        press_buttons(BTN_RIGHT, 3);
        score_stable <= 1'b0;
        press_buttons(BTN_UP, 1);
        wait_for_score(SEG_ZERO, SEG_ZERO, 500);

        score_stable <= 1'b0;
        press_buttons(BTN_UP, 15);
        wait_for_score(SEG_ZERO, SEG_ONE, 500);

        score_stable <= 1'b0;
        press_buttons(BTN_ALL, 1);
        wait_for_score(SEG_ZERO, SEG_ZERO, 500);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- design/frogger_top.sv
`timescale 1ns/1ps
`include "frogger_config.svh"

module frogger_top #(
    parameter int CAR_TICK = `CAR_TICK_DEFAULT,
    parameter int DEBOUNCE_CYCLES = `DEBOUNCE_DEFAULT
) (
    input  logic                   i_CLK,
    input  logic                   i_rst,
    input  frogger_pkg::buttons_t  i_buttons,
    output logic                   o_hsync,
    output logic                   o_vsync,
    output frogger_pkg::rgb_t      o_rgb,
    output frogger_pkg::seg_t      o_seg_tens,
    output frogger_pkg::seg_t      o_seg_ones
);

    frogger_pkg::scan_t scan;
    frogger_pkg::buttons_t press;
    frogger_pkg::frog_t frog;
    frogger_pkg::score_t score;
    frogger_pkg::cars_t cars;
    logic clear;
    logic win;
    logic collide;

    vga_timing u_vga_timing (
        .i_CLK   (i_CLK),
        .i_rst   (i_rst),
        .o_scan  (scan),
        .o_hsync (o_hsync),
        .o_vsync (o_vsync)
    );

    button_press #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_button_press (
        .i_CLK     (i_CLK),
        .i_rst     (i_rst),
        .i_buttons (i_buttons),
        .o_press   (press),
        .o_clear   (clear)
    );

    frog_control u_frog_control (
        .i_CLK     (i_CLK),
        .i_rst     (i_rst),
        .i_press   (press),
        .i_clear   (clear),
        .i_collide (collide),
        .o_frog    (frog),
        .o_score   (score),
        .o_win     (win)
    );

    traffic #(
        .CAR_TICK (CAR_TICK)
    ) u_traffic (
        .i_CLK     (i_CLK),
        .i_rst     (i_rst),
        .i_frog    (frog),
        .i_win     (win),
        .i_clear   (clear),
        .i_score   (score),
        .o_cars    (cars),
        .o_collide (collide)
    );

    score_display u_score_display (
        .i_CLK      (i_CLK),
        .i_rst      (i_rst),
        .i_score    (score),
        .o_seg_tens (o_seg_tens),
        .o_seg_ones (o_seg_ones)
    );

    pixel_render u_pixel_render (
        .i_CLK  (i_CLK),
        .i_rst  (i_rst),
        .i_scan (scan),
        .i_frog (frog),
        .i_cars (cars),
        .o_rgb  (o_rgb)
    );

endmodule

//--- design/pixel_render.sv
`timescale 1ns/1ps
`include "frogger_config.svh"

module pixel_render (
    input  logic                i_CLK,
    input  logic                i_rst,
    input  frogger_pkg::scan_t  i_scan,
    input  frogger_pkg::frog_t  i_frog,
    input  frogger_pkg::cars_t  i_cars,
    output frogger_pkg::rgb_t   o_rgb
);

    logic [4:0] tile_col;
    logic [4:0] tile_row;
    logic frog_hit;
    logic car_hit;
    logic grass_row;

    // Tile coordinates of the current pixel
    assign tile_col = i_scan.x[9:5];
    assign tile_row = i_scan.y[9:5];

    assign frog_hit = (tile_col == i_frog.col) && (tile_row == {1'b0, i_frog.row});

    always_comb begin
        car_hit = 1'b0;
        for (int i = 0; i < `NUM_CARS; i++) begin
            if (tile_row == {1'b0, i_cars[i].row} &&
                i_scan.x >= i_cars[i].x &&
                i_scan.x < i_cars[i].x + 10'(`TILE)) begin
                car_hit = 1'b1;
            end
        end
    end

    // Safe strips at both ends and the median
    assign grass_row = (tile_row == 5'd0) || (tile_row == 5'd7) ||
                       (tile_row == 5'd8) || (tile_row == 5'd14);

    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            o_rgb <= '0;
        end else if (!i_scan.video_on) begin
            o_rgb <= '0;
        end else if (frog_hit) begin
            o_rgb <= `COLOR_FROG;
        end else if (car_hit) begin
            o_rgb <= `COLOR_CAR;
        end else if (grass_row) begin
            o_rgb <= `COLOR_GRASS;
        end else begin
            o_rgb <= `COLOR_ROAD;
        end
    end

endmodule

//--- design/score_display.sv
`timescale 1ns/1ps

module score_display (
    input  logic                 i_CLK,
    input  logic                 i_rst,
    input  frogger_pkg::score_t  i_score,
    output frogger_pkg::seg_t    o_seg_tens,
    output frogger_pkg::seg_t    o_seg_ones
);

    function automatic frogger_pkg::seg_t seg_code(input logic [3:0] digit);
        case (digit)
            4'd0:    seg_code = 7'b0000001;
            4'd1:    seg_code = 7'b1001111;
            4'd2:    seg_code = 7'b0010010;
            4'd3:    seg_code = 7'b0000110;
            4'd4:    seg_code = 7'b1001100;
            4'd5:    seg_code = 7'b0100100;
            4'd6:    seg_code = 7'b0100000;
            4'd7:    seg_code = 7'b0001111;
            4'd8:    seg_code = 7'b0000000;
            4'd9:    seg_code = 7'b0000100;
            default: seg_code = 7'b1111111;
        endcase
    endfunction

    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            o_seg_tens <= seg_code(4'd0);
            o_seg_ones <= seg_code(4'd0);
        end else begin
            o_seg_tens <= seg_code(4'(i_score / 7'd10));
            o_seg_ones <= seg_code(4'(i_score % 7'd10));
        end
    end

endmodule

//--- design/traffic.sv
`timescale 1ns/1ps
`include "frogger_config.svh"

module traffic #(
    parameter int CAR_TICK = `CAR_TICK_DEFAULT
) (
    input  logic                 i_CLK,
    input  logic                 i_rst,
    input  frogger_pkg::frog_t   i_frog,
    input  logic                 i_win,
    input  logic                 i_clear,
    input  frogger_pkg::score_t  i_score,
    output frogger_pkg::cars_t   o_cars,
    output logic                 o_collide
);

    frogger_pkg::tick_t period;
    frogger_pkg::tick_t tick_count;
    frogger_pkg::score_t prev_score;
    frogger_pkg::row_t lane_row [`NUM_CARS];
    frogger_pkg::pix_t frog_left;
    frogger_pkg::pix_t frog_right;
    logic step;
    logic hit;

    assign step = (tick_count >= period);

    // Score has already counted this win
    assign prev_score = (i_score == '0) ? 7'(`SCORE_MAX) : i_score - 7'd1;

    // Lanes follow the frog up the screen
    always_comb begin
        case (i_frog.row)
            4'd12, 4'd13, 4'd14: lane_row = '{4'd11, 4'd12, 4'd13};
            4'd11:               lane_row = '{4'd11, 4'd12, 4'd10};
            4'd8, 4'd9, 4'd10:   lane_row = '{4'd11, 4'd9, 4'd10};
            4'd5, 4'd6, 4'd7:    lane_row = '{4'd4, 4'd5, 4'd6};
            4'd4:                lane_row = '{4'd4, 4'd5, 4'd3};
            4'd3:                lane_row = '{4'd4, 4'd2, 4'd3};
            default:             lane_row = '{4'd1, 4'd2, 4'd3};
        endcase
    end

    assign frog_left = 10'(i_frog.col * `TILE);
    assign frog_right = frog_left + 10'(`TILE);

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < `NUM_CARS; i++) begin
            if (i_frog.row == o_cars[i].row &&
                ((frog_left >= o_cars[i].x && frog_left <= o_cars[i].x + 10'(`TILE)) ||
                 (frog_right >= o_cars[i].x && frog_right <= o_cars[i].x + 10'(`TILE)))) begin
                hit = 1'b1;
            end
        end
    end

    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            tick_count <= '0;
            period <= 32'(CAR_TICK);
            o_collide <= 1'b0;
            o_cars[0] <= '{x: 10'(`CAR0_X), row: 4'd11};
            o_cars[1] <= '{x: 10'(`CAR1_X), row: 4'd12};
            o_cars[2] <= '{x: 10'(`CAR2_X), row: 4'd13};
        end else begin
            // One pulse per overlap
            o_collide <= hit && !o_collide;
            if (step) begin
                tick_count <= '0;
                for (int i = 0; i < `NUM_CARS; i++) begin
                    o_cars[i].row <= lane_row[i];
                    // Odd cars drive left
                    if (i % 2 == 1) begin
                        o_cars[i].x <= (o_cars[i].x == '0) ?
                            10'(`SCREEN_WRAP) : o_cars[i].x - 10'd1;
                    end else begin
                        o_cars[i].x <= (o_cars[i].x == 10'(`SCREEN_WRAP)) ?
                            '0 : o_cars[i].x + 10'd1;
                    end
                end
            end else begin
                tick_count <= tick_count + 32'd1;
            end
            if (i_clear || o_collide) begin
                period <= 32'(CAR_TICK);
            end else if (i_win && prev_score % 7'd3 == 7'd0 &&
                         period > 32'(`SPEED_STEP)) begin
                period <= period - 32'(`SPEED_STEP);
            end
        end
    end

endmodule

//--- design/frog_control.sv
`timescale 1ns/1ps
`include "frogger_config.svh"

module frog_control (
    input  logic                   i_CLK,
    input  logic                   i_rst,
    input  frogger_pkg::buttons_t  i_press,
    input  logic                   i_clear,
    input  logic                   i_collide,
    output frogger_pkg::frog_t     o_frog,
    output frogger_pkg::score_t    o_score,
    output logic                   o_win
);

    localparam frogger_pkg::frog_t HOME = '{
        col: 5'(`FROG_HOME_COL),
        row: 4'(`FROG_HOME_ROW)
    };

    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            o_frog <= HOME;
            o_score <= '0;
            o_win <= 1'b0;
        end else begin
            o_win <= 1'b0;
            if (i_clear || i_collide) begin
                o_frog <= HOME;
                o_score <= '0;
            end else if (i_press.up && o_frog.row == 4'd0) begin
                // Made it across
                o_frog <= HOME;
                o_win <= 1'b1;
                if (o_score == 7'(`SCORE_MAX)) begin
                    o_score <= '0;
                end else begin
                    o_score <= o_score + 7'd1;
                end
            end else begin
                if (i_press.up && o_frog.row != 4'd0) begin
                    o_frog.row <= o_frog.row - 4'd1;
                end
                if (i_press.down && o_frog.row != 4'(`GRID_ROWS - 1)) begin
                    o_frog.row <= o_frog.row + 4'd1;
                end
                if (i_press.left && o_frog.col != 5'd0) begin
                    o_frog.col <= o_frog.col - 5'd1;
                end
                if (i_press.right && o_frog.col != 5'(`GRID_COLS - 1)) begin
                    o_frog.col <= o_frog.col + 5'd1;
                end
            end
        end
    end

endmodule

//--- design/button_press.sv
`timescale 1ns/1ps
`include "frogger_config.svh"

module button_press #(
    parameter int DEBOUNCE_CYCLES = `DEBOUNCE_DEFAULT
) (
    input  logic                   i_CLK,
    input  logic                   i_rst,
    input  frogger_pkg::buttons_t  i_buttons,
    output frogger_pkg::buttons_t  o_press,
    output logic                   o_clear
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [3:0] sync_q1;
    logic [3:0] sync_q2;
    logic [CNT_W-1:0] count [4];
    frogger_pkg::buttons_t stable;
    frogger_pkg::buttons_t stable_d;

    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            sync_q1 <= '1;
            sync_q2 <= '1;
            stable <= '1;
            stable_d <= '1;
            for (int i = 0; i < 4; i++) begin
                count[i] <= '0;
            end
        end else begin
            sync_q1 <= i_buttons;
            sync_q2 <= sync_q1;
            stable_d <= stable;
            for (int i = 0; i < 4; i++) begin
                if (sync_q2[i] == stable[i]) begin
                    count[i] <= '0;
                end else if (count[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    // Level held long enough, accept it
                    count[i] <= '0;
                    stable[i] <= sync_q2[i];
                end else begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    // Falling edge of the debounced level is a press
    assign o_press = stable_d & ~stable;
    assign o_clear = (stable == '0) && (stable_d != '0);

endmodule

//--- design/vga_timing.sv
`timescale 1ns/1ps
`include "frogger_config.svh"

module vga_timing (
    input  logic                i_CLK,
    input  logic                i_rst,
    output frogger_pkg::scan_t  o_scan,
    output logic                o_hsync,
    output logic                o_vsync
);

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;

    frogger_pkg::pix_t h_count;
    frogger_pkg::pix_t v_count;

    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == 10'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == 10'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 10'd1;
            end
        end else begin
            h_count <= h_count + 10'd1;
        end
    end

    // Sync pulses are active low
    assign o_hsync = !(h_count >= 10'(H_SYNC_START) && h_count < 10'(H_SYNC_START + `H_SYNC));
    assign o_vsync = !(v_count >= 10'(V_SYNC_START) && v_count < 10'(V_SYNC_START + `V_SYNC));

    assign o_scan.x = h_count;
    assign o_scan.y = v_count;
    assign o_scan.video_on = (h_count < 10'(`H_ACTIVE)) && (v_count < 10'(`V_ACTIVE));

endmodule

//--- design/frogger_pkg.sv
`include "frogger_config.svh"

package frogger_pkg;

    typedef logic [9:0] pix_t;
    typedef logic [4:0] col_t;
    typedef logic [3:0] row_t;
    typedef logic [5:0] rgb_t;
    // Segments a..g, low lights the segment
    typedef logic [6:0] seg_t;
    typedef logic [6:0] score_t;
    typedef logic [31:0] tick_t;

    typedef struct packed {
        logic up;
        logic left;
        logic right;
        logic down;
    } buttons_t;

    typedef struct packed {
        col_t col;
        row_t row;
    } frog_t;

    typedef struct packed {
        pix_t x;
        row_t row;
    } car_t;

    typedef car_t [`NUM_CARS-1:0] cars_t;

    typedef struct packed {
        pix_t x;
        pix_t y;
        logic video_on;
    } scan_t;

endpackage

//--- include/frogger_config.svh
`ifndef FROGGER_CONFIG_SVH
`define FROGGER_CONFIG_SVH

// 640x480 at 60 Hz with a 25 MHz pixel clock
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// Playfield grid
`define TILE 32
`define GRID_COLS 20
`define GRID_ROWS 15
`define FROG_HOME_COL 10
`define FROG_HOME_ROW 14

// Traffic
`define SCREEN_WRAP 608
`define NUM_CARS 3
`define CAR0_X 100
`define CAR1_X 0
`define CAR2_X 400
`define CAR_TICK_DEFAULT 166667
`define SPEED_STEP 8333

`define DEBOUNCE_DEFAULT 250000

// RRGGBB
`define COLOR_GRASS 6'b00_10_00
`define COLOR_ROAD 6'b01_01_01
`define COLOR_FROG 6'b10_11_00
`define COLOR_CAR 6'b11_00_00

`define SCORE_MAX 99

`endif
